/* hw/exec_macros.svh */
`ifndef EXEC_MACROS_SVH
`define EXEC_MACROS_SVH

// one machine word
`define EXEC_DATA_W 16

// input queue entries, also the initial decode credit
`define EXEC_QUEUE_DEPTH 4

// results writeback can absorb
`define EXEC_OUT_CREDITS 2

`define EXEC_TAG_W 3

`endif

/* hw/isaPkg.sv */
package isaPkg;

    typedef logic [4:0] aluOpT;
    typedef logic [1:0] functT;

    // immediate forms
    localparam aluOpT opAddi   = 5'b01000;
    localparam aluOpT opSubi   = 5'b01001;
    localparam aluOpT opXori   = 5'b01010;
    localparam aluOpT opAndni  = 5'b01011;
    localparam aluOpT opBltz   = 5'b01110;
    localparam aluOpT opBgez   = 5'b01111;
    localparam aluOpT opSt     = 5'b10000;
    localparam aluOpT opLd     = 5'b10001;
    localparam aluOpT opSlbi   = 5'b10010;
    localparam aluOpT opStu    = 5'b10011;
    localparam aluOpT opRoli   = 5'b10100;
    localparam aluOpT opSlli   = 5'b10101;
    localparam aluOpT opRori   = 5'b10110;
    localparam aluOpT opSrli   = 5'b10111;
    localparam aluOpT opLbi    = 5'b11000;
    localparam aluOpT opBtr    = 5'b11001;
    localparam aluOpT opShiftR = 5'b11010; // rol, sll, ror, srl by funct
    localparam aluOpT opArithR = 5'b11011; // add, sub, xor, andn by funct
    localparam aluOpT opSeq    = 5'b11100;
    localparam aluOpT opSlt    = 5'b11101;
    localparam aluOpT opSle    = 5'b11110;
    localparam aluOpT opSco    = 5'b11111;

    // funct values of the register arithmetic group
    localparam functT fnAdd  = 2'b00;
    localparam functT fnSub  = 2'b01;
    localparam functT fnXor  = 2'b10;
    localparam functT fnAndn = 2'b11;

    typedef enum logic [2:0] {
        selRol  = 3'b000,
        selSll  = 3'b001,
        selRor  = 3'b010,
        selSrl  = 3'b011,
        selAdd  = 3'b100,
        selOr   = 3'b101,
        selXor  = 3'b110,
        selAndn = 3'b111
    } aluSelT;

    typedef struct packed {
        logic   invA;
        logic   invB;
        logic   sign;   // signed overflow instead of carry
        logic   cIn;
        aluSelT aluSel;
    } aluCtrlT;

endpackage

/* hw/execPkg.sv */
`include "exec_macros.svh"

package execPkg;

    import isaPkg::*;

    // one decoded request from decode
    typedef struct packed {
        aluOpT                   aluOp;
        functT                   funct;
        logic [`EXEC_DATA_W-1:0] operandA;
        logic [`EXEC_DATA_W-1:0] operandB;
        logic [`EXEC_TAG_W-1:0]  tag;
    } execReqT;

    // one result toward writeback
    typedef struct packed {
        logic [`EXEC_DATA_W-1:0] result;
        logic                    ofl;
        logic                    zero;
        logic [`EXEC_TAG_W-1:0]  tag;   // copied from the request
    } execResT;

endpackage

/* hw/aluControl.sv */
`timescale 1ns/10ps

module aluControl import isaPkg::*; (
    input  aluOpT   aluOp,
    input  functT   funct,
    output aluCtrlT ctrl
);

    always_comb begin
        ctrl = '0; // halt, nop and anything unlisted decode to plain rol

        case (aluOp)
            opAddi: begin
                ctrl.sign   = 1'b1;
                ctrl.aluSel = selAdd;
            end
            opSubi: begin
                ctrl.invA   = 1'b1; // B - A
                ctrl.cIn    = 1'b1;
                ctrl.aluSel = selAdd;
            end
            opXori: begin
                ctrl.aluSel = selXor;
            end
            opAndni: begin
                ctrl.invB   = 1'b1;
                ctrl.aluSel = selAndn;
            end
            opRoli: begin
                ctrl.aluSel = selRol;
            end
            opSlli: begin
                ctrl.aluSel = selSll;
            end
            opRori: begin
                ctrl.aluSel = selRor;
            end
            opSrli: begin
                ctrl.aluSel = selSrl;
            end
            opSt, opLd, opStu, opBtr, opLbi, opSco: begin
                ctrl.aluSel = selAdd; // address or pass-through add
            end
            opSlbi: begin
                ctrl.aluSel = selOr; // no pre-shift here
            end
            opArithR: begin
                case (funct)
                    fnAdd: begin
                        ctrl.aluSel = selAdd;
                    end
                    fnSub: begin
                        ctrl.invA   = 1'b1;
                        ctrl.cIn    = 1'b1;
                        ctrl.aluSel = selAdd;
                    end
                    fnXor: begin
                        ctrl.aluSel = selXor;
                    end
                    default: begin // fnAndn
                        ctrl.invB   = 1'b1;
                        ctrl.aluSel = selAndn;
                    end
                endcase
            end
            opShiftR: begin
                ctrl.aluSel = aluSelT'({1'b0, funct}); // funct order is rol, sll, ror, srl
            end
            opSeq: begin
                ctrl.invA   = 1'b1;
                ctrl.cIn    = 1'b1;
                ctrl.aluSel = selAdd;
            end
            opSlt, opSle: begin
                ctrl.sign   = 1'b1; // A - B, signed
                ctrl.invB   = 1'b1;
                ctrl.cIn    = 1'b1;
                ctrl.aluSel = selAdd;
            end
            opBltz, opBgez: begin
                ctrl.sign   = 1'b1;
                ctrl.invB   = 1'b1;
                ctrl.cIn    = 1'b1;
                ctrl.aluSel = selAdd;
            end
            default: begin
                ctrl = '0;
            end
        endcase
    end

endmodule

/* hw/shifter.sv */
`timescale 1ns/10ps
`include "exec_macros.svh"

module shifter (
    input  logic [`EXEC_DATA_W-1:0] data,
    input  logic [3:0]              amount,
    input  logic [1:0]              mode,   // rol, sll, ror, srl
    output logic [`EXEC_DATA_W-1:0] result
);

    localparam int dataW = `EXEC_DATA_W;

    logic [4:0][dataW-1:0] stage; // stage 0 is the input

    assign stage[0] = data;

    for (genvar i = 0; i < 4; i++) begin : gLevel
        localparam int shAmt = 1 << i;

        logic [dataW-1:0] moved;

        always_comb begin
            case (mode)
                2'b00: moved = {stage[i][dataW-1-shAmt:0], stage[i][dataW-1:dataW-shAmt]};
                2'b01: moved = {stage[i][dataW-1-shAmt:0], {shAmt{1'b0}}};
                2'b10: moved = {stage[i][shAmt-1:0], stage[i][dataW-1:shAmt]};
                default: moved = {{shAmt{1'b0}}, stage[i][dataW-1:shAmt]};
            endcase
        end

        assign stage[i+1] = amount[i] ? moved : stage[i]; // bit i moves by 2**i
    end

    assign result = stage[4];

endmodule

/* hw/alu.sv */
`timescale 1ns/10ps
`include "exec_macros.svh"

module alu import isaPkg::*; (
    input  logic [`EXEC_DATA_W-1:0] a,
    input  logic [`EXEC_DATA_W-1:0] b,
    input  aluCtrlT                 ctrl,
    output logic [`EXEC_DATA_W-1:0] result,
    output logic                    ofl,
    output logic                    zero
);

    localparam int dataW = `EXEC_DATA_W;

    logic [dataW-1:0] opA;
    logic [dataW-1:0] opB;
    logic [dataW-1:0] sum;
    logic [dataW-1:0] shiftOut;
    logic             carryOut;
    logic             signedOfl;

    assign opA = ctrl.invA ? ~a : a;
    assign opB = ctrl.invB ? ~b : b;

    // one adder for add, sub and compares
    assign {carryOut, sum} = {1'b0, opA} + {1'b0, opB} + {{dataW{1'b0}}, ctrl.cIn};

    // operands agree in sign but the sum does not
    assign signedOfl = (opA[dataW-1] == opB[dataW-1]) && (sum[dataW-1] != opA[dataW-1]);

    shifter shift0 (
        .data   (a),
        .amount (b[3:0]),
        .mode   (ctrl.aluSel[1:0]),
        .result (shiftOut)
    );

    always_comb begin
        case (ctrl.aluSel)
            selAdd:  result = sum;
            selOr:   result = opA | opB;
            selXor:  result = opA ^ opB;
            selAndn: result = opA & opB; // invB is set by the decoder
            default: result = shiftOut;
        endcase
    end

    assign ofl  = (ctrl.aluSel == selAdd) ? (ctrl.sign ? signedOfl : carryOut) : 1'b0;
    assign zero = (result == '0);

endmodule

/* hw/creditQueue.sv */
`timescale 1ns/10ps
`include "exec_macros.svh"

module creditQueue #(
    parameter type payloadT = logic
) (
    input  logic    clk,
    input  logic    rstN,
    input  logic    push,
    input  payloadT pushData,
    input  logic    pop,
    output payloadT popData,
    output logic    notEmpty,
    output logic    credit    // one pulse per freed slot
);

    localparam int depth = `EXEC_QUEUE_DEPTH;
    localparam int ptrW  = $clog2(depth);
    localparam int cntW  = $clog2(depth + 1);

    payloadT         mem [depth];
    logic [ptrW-1:0] rdPtr;
    logic [ptrW-1:0] wrPtr;
    logic [cntW-1:0] count;
    logic            doPop;

    function automatic logic [ptrW-1:0] nextPtr(input logic [ptrW-1:0] ptr);
        return (ptr == ptrW'(depth - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign notEmpty = (count != '0);
    assign doPop    = pop && notEmpty;
    assign popData  = mem[rdPtr]; // head visible right after the push edge

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wrPtr] <= pushData;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            rdPtr  <= '0;
            wrPtr  <= '0;
            count  <= '0;
            credit <= 1'b0;
        end else begin
            if (push) begin
                wrPtr <= nextPtr(wrPtr);
            end
            if (doPop) begin
                rdPtr <= nextPtr(rdPtr);
            end
            count  <= count + cntW'(push) - cntW'(doPop);
            credit <= doPop;
        end
    end

endmodule

/* hw/execUnit.sv */
`timescale 1ns/10ps
`include "exec_macros.svh"

module execUnit import isaPkg::*, execPkg::*; (
    input  logic    clk,
    input  logic    rstN,
    input  logic    reqValid,
    input  execReqT req,
    output logic    reqCredit,
    output logic    resValid,
    output execResT res,
    input  logic    resCredit
);

    localparam int credW = $clog2(`EXEC_OUT_CREDITS + 1);

    execReqT                 head;
    logic                    headValid;
    logic                    doPop;
    aluCtrlT                 ctrl;
    logic [`EXEC_DATA_W-1:0] aluResult;
    logic                    aluOfl;
    logic                    aluZero;
    logic [credW-1:0]        outCredits; // free slots in writeback

    creditQueue #(
        .payloadT (execReqT)
    ) reqQueue (
        .clk      (clk),
        .rstN     (rstN),
        .push     (reqValid),
        .pushData (req),
        .pop      (doPop),
        .popData  (head),
        .notEmpty (headValid),
        .credit   (reqCredit)
    );

    assign doPop = headValid && (outCredits != '0);

    aluControl dec0 (
        .aluOp (head.aluOp),
        .funct (head.funct),
        .ctrl  (ctrl)
    );

    alu alu0 (
        .a      (head.operandA),
        .b      (head.operandB),
        .ctrl   (ctrl),
        .result (aluResult),
        .ofl    (aluOfl),
        .zero   (aluZero)
    );

    always_ff @(posedge clk) begin
        if (!rstN) begin
            resValid   <= 1'b0;
            outCredits <= credW'(`EXEC_OUT_CREDITS);
        end else begin
            resValid   <= doPop;
            // a credit is spent on the edge that raises resValid
            outCredits <= outCredits + credW'(resCredit) - credW'(doPop);
        end
    end

    always_ff @(posedge clk) begin
        if (doPop) begin
            res <= '{result: aluResult, ofl: aluOfl, zero: aluZero, tag: head.tag};
        end
    end

endmodule

/* dv/execUnit_assert.sv */
`timescale 1ns/10ps
`include "exec_macros.svh"

module execUnit_assert (
    input logic                                  clk,
    input logic                                  rstN,
    input logic                                  reqValid,
    input logic                                  reqCredit,
    input logic                                  resValid,
    input logic                                  resCredit,
    input logic                                  headValid,
    input logic [$clog2(`EXEC_OUT_CREDITS+1)-1:0] outCredits
);

    localparam int queueDepth = `EXEC_QUEUE_DEPTH;
    localparam int outMax     = `EXEC_OUT_CREDITS;

    int accepted; // requests pushed by decode
    int returned; // reqCredit pulses seen
    int results;  // resValid cycles seen
    int acked;    // resCredit pulses seen

    always_ff @(posedge clk) begin
        if (!rstN) begin
            accepted <= 0;
            returned <= 0;
            results  <= 0;
            acked    <= 0;
        end else begin
            accepted <= accepted + int'(reqValid);
            returned <= returned + int'(reqCredit);
            results  <= results + int'(resValid);
            acked    <= acked + int'(resCredit);
        end
    end

    creditNotAhead: assert property (@(posedge clk) disable iff (!rstN)
        reqCredit |-> returned < accepted)
        else $error("input credit returned without a matching request");

    // a credit pulse in flight is already usable by decode
    decodeHasCredit: assert property (@(posedge clk) disable iff (!rstN)
        reqValid |-> (accepted - returned - int'(reqCredit)) < queueDepth)
        else $error("request offered with no decode credit left");

    outputWithinCredit: assert property (@(posedge clk) disable iff (!rstN)
        resValid |-> (results - acked) < outMax)
        else $error("result issued beyond the writeback credit limit");

    inputCreditsBack: assert property (@(posedge clk) disable iff (!rstN)
        (!headValid && !reqValid) |=> accepted == returned)
        else $error("input credits missing after the queue drained");

    outputCreditsBack: assert property (@(posedge clk) disable iff (!rstN)
        (!resValid && results == acked) |-> int'(outCredits) == outMax)
        else $error("output credit count not full after writeback drained");

    resetQuiet: assert property (@(posedge clk)
        $rose(rstN) |=> (!resValid && !reqCredit))
        else $error("valid or credit high right after reset");

endmodule

bind execUnit execUnit_assert assert0 (
    .clk        (clk),
    .rstN       (rstN),
    .reqValid   (reqValid),
    .reqCredit  (reqCredit),
    .resValid   (resValid),
    .resCredit  (resCredit),
    .headValid  (headValid),
    .outCredits (outCredits)
);

/* dv/execUnitTb.sv */
`timescale 1ns/10ps
`include "exec_macros.svh"

module execUnitTb import isaPkg::*, execPkg::*; ();

    localparam int dataW      = `EXEC_DATA_W;
    localparam int tagW       = `EXEC_TAG_W;
    localparam int numReq     = 200;
    localparam int cycleLimit = 20 * numReq + 200;

    logic    clk;
    logic    rstN;
    logic    reqValid;
    execReqT req;
    logic    reqCredit;
    logic    resValid;
    execResT res;
    logic    resCredit;

    int      seed;
    int      sent;
    int      received;
    int      decCredits; // decode side view of free queue slots
    int      wbPending;  // results held by writeback, not yet credited
    int      cycles;
    execResT expQ[$];
    string   nameQ[$];

    execUnit dut0 (
        .clk       (clk),
        .rstN      (rstN),
        .reqValid  (reqValid),
        .req       (req),
        .reqCredit (reqCredit),
        .resValid  (resValid),
        .res       (res),
        .resCredit (resCredit)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic stopOnFailure(input string reason);
        $display(">>> FAIL");
        $fatal(1, "%s", reason);
    endtask

    // {ofl, sum}; ofl is signed overflow or carry out
    function automatic logic [dataW:0] addWord(input logic [dataW-1:0] x,
                                               input logic [dataW-1:0] y,
                                               input logic cin, input logic isSigned);
        logic [dataW:0]   wide;
        logic             over;
        wide = {1'b0, x} + {1'b0, y} + {{dataW{1'b0}}, cin};
        over = (x[dataW-1] == y[dataW-1]) && (wide[dataW-1] != x[dataW-1]);
        return {isSigned ? over : wide[dataW], wide[dataW-1:0]};
    endfunction

    // mode 0 rol, 1 sll, 2 ror, 3 srl
    function automatic logic [dataW:0] shiftWord(input logic [dataW-1:0] d,
                                                 input logic [3:0] amt, input logic [1:0] mode);
        logic [dataW-1:0] r;
        case (mode)
            2'd0: r = (d << amt) | (d >> (dataW - amt));
            2'd1: r = d << amt;
            2'd2: r = (d >> amt) | (d << (dataW - amt));
            default: r = d >> amt;
        endcase
        return {1'b0, r};
    endfunction

    function automatic execResT expectResult(input execReqT r);
        logic [dataW-1:0] a;
        logic [dataW-1:0] b;
        logic [dataW:0]   out;
        execResT          e;
        a = r.operandA;
        b = r.operandB;
        case (r.aluOp)
            opAddi: out = addWord(a, b, 1'b0, 1'b1);
            opSubi, opSeq: out = addWord(~a, b, 1'b1, 1'b0); // b - a
            opSlt, opSle, opBltz, opBgez: out = addWord(a, ~b, 1'b1, 1'b1); // a - b
            opSt, opLd, opStu, opBtr, opLbi, opSco: out = addWord(a, b, 1'b0, 1'b0);
            opXori: out = {1'b0, a ^ b};
            opAndni: out = {1'b0, a & ~b};
            opSlbi: out = {1'b0, a | b};
            opRoli: out = shiftWord(a, b[3:0], 2'd0);
            opSlli: out = shiftWord(a, b[3:0], 2'd1);
            opRori: out = shiftWord(a, b[3:0], 2'd2);
            opSrli: out = shiftWord(a, b[3:0], 2'd3);
            opShiftR: out = shiftWord(a, b[3:0], r.funct);
            opArithR: begin
                case (r.funct)
                    2'd0: out = addWord(a, b, 1'b0, 1'b0);
                    2'd1: out = addWord(~a, b, 1'b1, 1'b0);
                    2'd2: out = {1'b0, a ^ b};
                    default: out = {1'b0, a & ~b};
                endcase
            end
            default: out = shiftWord(a, b[3:0], 2'd0); // halt, nop and holes act as rol
        endcase
        e.result = out[dataW-1:0];
        e.ofl    = out[dataW];
        e.zero   = (out[dataW-1:0] == '0);
        e.tag    = r.tag;
        return e;
    endfunction

    function automatic string groupName(input execReqT r);
        case (r.aluOp)
            opXori, opAndni, opSlbi: return "logic";
            opArithR: return r.funct[1] ? "logic" : "arithmetic";
            opRoli, opSlli, opRori, opSrli, opShiftR: return "shift";
            opAddi, opSubi, opSeq, opSlt, opSle, opBltz, opBgez: return "arithmetic";
            opSt, opLd, opStu, opBtr, opLbi, opSco: return "arithmetic";
            default: return "undefined as rol";
        endcase
    endfunction

    task automatic sendRequest();
        execReqT r;
        r.aluOp    = aluOpT'($random(seed));
        r.funct    = functT'($random(seed));
        r.operandA = dataW'($random(seed));
        r.operandB = (($random(seed) & 3) == 0) ? r.operandA : dataW'($random(seed));
        r.tag      = tagW'(sent);
        req        = r;
        reqValid   = 1'b1;
        expQ.push_back(expectResult(r));
        nameQ.push_back(groupName(r));
        decCredits--;
        sent++;
    endtask

    task automatic checkResult();
        execResT expected;
        string   name;
        assert (expQ.size() != 0) else begin
            stopOnFailure("result arrived with no request outstanding");
        end
        expected = expQ.pop_front();
        name     = nameQ.pop_front();
        received++;
        wbPending++;
        assert (res === expected) else begin
            $display("Error: %s tag %0d expected %h actual %h", name, expected.tag,
                     expected, res);
            stopOnFailure("result differs from the reference model");
        end
    endtask

    always @(posedge clk) begin
        cycles++;
        if (cycles > cycleLimit) begin
            stopOnFailure($sformatf("run did not finish within %0d cycles", cycleLimit));
        end
    end

    initial begin
        seed       = 32'h6e647803;
        sent       = 0;
        received   = 0;
        decCredits = `EXEC_QUEUE_DEPTH;
        wbPending  = 0;
        cycles     = 0;
        rstN       = 1'b0;
        reqValid   = 1'b0;
        req        = '0;
        resCredit  = 1'b0;
        repeat (3) @(negedge clk);
        rstN = 1'b1;

        while (received < numReq || wbPending != 0) begin
            @(negedge clk);
            if (reqCredit) begin
                decCredits++;
            end
            if (resValid) begin
                checkResult();
            end
            resCredit = 1'b0;
            if (wbPending != 0 && (sent == numReq || ($random(seed) & 3) != 0)) begin
                resCredit = 1'b1; // withheld about a quarter of the time
                wbPending--;
            end
            reqValid = 1'b0;
            if (sent < numReq && decCredits != 0 && ($random(seed) & 1) != 0) begin
                sendRequest();
            end
        end

        repeat (5) begin // idle cycles for the drain checks
            @(negedge clk);
            resCredit = 1'b0;
            if (reqCredit) begin
                decCredits++;
            end
            if (resValid) begin
                checkResult();
            end
        end
        if (decCredits == `EXEC_QUEUE_DEPTH) begin
            $display(">>> PASS");
            $finish;
        end else begin
            stopOnFailure("input credits were lost or returned twice");
        end
    end

endmodule

/* wiscExec.f */
+incdir+hw
hw/isaPkg.sv
hw/execPkg.sv
hw/aluControl.sv
hw/shifter.sv
hw/alu.sv
hw/creditQueue.sv
hw/execUnit.sv
dv/execUnit_assert.sv
dv/execUnitTb.sv

/* Makefile */
all: run

build:
	verilator --binary --timing --assert -f wiscExec.f --top-module execUnitTb -Mdir obj_dir

run: build
	./obj_dir/VexecUnitTb | tee sim.log
	grep -q ">>> PASS" sim.log

lint:
	verilator --lint-only --timing --assert -f wiscExec.f --top-module execUnitTb

clean:
	rm -rf obj_dir sim.log

.PHONY: all build run lint clean
